/* project.f */
hw/owt_pkg.sv
hw/hv_reg_pkg.sv
hw/hv_owt_rx.sv
hw/hv_owt_tx.sv
hw/hv_reg_slv.sv
hw/hv_fault_proc.sv
hw/hv_core.sv
verification/tb_hv_core.sv

/* verification/tb_hv_core.sv */
//====================
// testbench for the hv side core
// owt driver and response monitor, reference model
// compare tasks, test sequence
//====================
`default_nettype none

module tb_hv_core import owt_pkg::*; import hv_reg_pkg::*; ();

    localparam int BIT_CYCLES   = OWT_BIT_CYCLES_DEF;
    localparam int DEGLITCH     = FLT_DEGLITCH_DEF;
    localparam int RSP_TIMEOUT  = 40 * BIT_CYCLES;  // whole request plus latency
    localparam int INTB_TIMEOUT = 200;

    logic          clk;
    logic          arst_n;
    logic          lv_hv_owt_rx;
    logic          hv_lv_owt_tx;
    hv_fault_t     hv_fault;
    drv_cfg_t      reg_config;
    logic          intb_n;

    // reference model state
    drv_cfg_t      ref_cfg;
    fault_status_t ref_mask;
    fault_status_t ref_status;
    logic [31:0]   rng_state;

    hv_core #(
        .OWT_BIT_CYCLES      (BIT_CYCLES),
        .FLT_DEGLITCH_CYCLES (DEGLITCH)
    ) dut_i (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .i_lv_hv_owt_rx (lv_hv_owt_rx),
        .o_hv_lv_owt_tx (hv_lv_owt_tx),
        .i_hv_fault     (hv_fault),
        .o_reg_config   (reg_config),
        .o_intb_n       (intb_n)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //====================
    // reference model
    //====================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // polynomial division of {cmd, data} * x^4 by x^4+x+1
    function automatic owt_crc_t ref_crc(input owt_cmd_t cmd, input owt_data_t data);
        logic [19:0] rem;
        rem = {cmd, data, 4'h0};
        for (int i = 19; i >= 4; i--) begin
            if (rem[i]) rem[i -: 5] = rem[i -: 5] ^ 5'b10011;
        end
        return rem[3:0];
    endfunction

    function automatic owt_data_t ref_read(input reg_addr_t addr);
        case (addr)
            4'd0:    return ref_cfg;
            4'd1:    return {1'b0, ref_mask};
            4'd2:    return {1'b0, ref_status};
            4'd3:    return 8'hA5;  // chip id
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic ref_intb();
        return ~|(ref_status & ~ref_mask);
    endfunction

    //====================
    // compare tasks
    //====================
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input owt_data_t got, input owt_data_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %02h, expected %02h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_crc(input string name, input owt_crc_t got, input owt_crc_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %01h, expected %01h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cfg(input string name, input drv_cfg_t got, input drv_cfg_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %02h, expected %02h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_intb(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    //====================
    // owt driver and monitor
    //====================
    task automatic send_frame(input owt_cmd_t cmd, input owt_data_t data, input logic bad_crc);
        owt_frame_t             frm;
        logic [OWT_FRAME_W+1:0] bits;
        frm.cmd  = cmd;
        frm.data = data;
        frm.crc  = bad_crc ? ~ref_crc(cmd, data) : ref_crc(cmd, data);
        bits     = {1'b0, frm, 1'b1};  // start, frame, stop
        @(negedge clk);
        for (int i = OWT_FRAME_W + 1; i >= 0; i--) begin
            lv_hv_owt_rx = bits[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic receive_response(output owt_frame_t frm);
        int                     cnt;
        logic [OWT_FRAME_W-1:0] sr;
        cnt = 0;
        while (hv_lv_owt_tx !== 1'b0) begin
            @(negedge clk);
            cnt++;
            if (cnt > RSP_TIMEOUT) begin
                $display("no response start bit seen on o_hv_lv_owt_tx");
                abort_run();
            end
        end
        repeat (BIT_CYCLES / 2) @(negedge clk);  // middle of start bit
        check_line("o_hv_lv_owt_tx start bit", hv_lv_owt_tx, 1'b0);
        for (int i = 0; i < OWT_FRAME_W; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            sr = {sr[OWT_FRAME_W-2:0], hv_lv_owt_tx};
        end
        repeat (BIT_CYCLES) @(negedge clk);
        check_line("o_hv_lv_owt_tx stop bit", hv_lv_owt_tx, 1'b1);
        frm = owt_frame_t'(sr);
    endtask

    task automatic write_reg(input reg_addr_t addr, input owt_data_t data);
        send_frame({1'b1, 3'b000, addr}, data, 1'b0);
        case (addr)
            4'd0:    ref_cfg = drv_cfg_t'(data);
            4'd1:    ref_mask = fault_status_t'(data[6:0]);
            4'd2:    ref_status = ref_status & ~fault_status_t'(data[6:0]);  // w1c
            default: ;
        endcase
    endtask

    task automatic read_check(input reg_addr_t addr);
        logic [31:0] rnd;
        owt_cmd_t    cmd;
        owt_frame_t  rsp;
        rnd = next_rand();
        cmd = {1'b0, rnd[2:0], addr};  // bits 6..4 are don't care
        fork
            send_frame(cmd, 8'h00, 1'b0);
            receive_response(rsp);
        join
        check_byte("rsp.cmd", rsp.cmd, cmd);
        check_byte("rsp.data", rsp.data, ref_read(addr));
        check_crc("rsp.crc", rsp.crc, ref_crc(cmd, ref_read(addr)));
    endtask

    task automatic wait_intb(input logic exp);
        int cnt;
        cnt = 0;
        while (intb_n !== exp) begin
            @(negedge clk);
            cnt++;
            if (cnt > INTB_TIMEOUT) begin
                $display("o_intb_n did not reach %b within %0d cycles", exp, INTB_TIMEOUT);
                abort_run();
            end
        end
    endtask

    //====================
    // test sequence
    //====================
    initial begin
        int          idx;
        logic [5:0]  flt_bits;
        logic [31:0] rnd;
        arst_n       = 1'b0;
        lv_hv_owt_rx = 1'b1;
        hv_fault     = '0;
        ref_cfg      = '0;
        ref_mask     = '0;
        ref_status   = '0;
        rng_state    = 32'd69226;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) @(negedge clk);

        check_intb("o_intb_n", intb_n, 1'b1);
        check_line("o_hv_lv_owt_tx", hv_lv_owt_tx, 1'b1);
        check_cfg("o_reg_config", reg_config, ref_cfg);
        read_check(REG_ADDR_ID);

        for (int n = 0; n < 6; n++) begin
            rnd = next_rand();
            write_reg(REG_ADDR_CONFIG, rnd[7:0]);
            check_cfg("o_reg_config", reg_config, ref_cfg);
            read_check(REG_ADDR_CONFIG);
        end
        rnd = next_rand();
        read_check(reg_addr_t'(4 + rnd % 12));  // unmapped

        // bad crc write must be dropped and flag com_err
        send_frame({1'b1, 3'b000, REG_ADDR_CONFIG}, ~ref_cfg, 1'b1);
        ref_status.com_err = 1'b1;
        wait_intb(ref_intb());
        check_cfg("o_reg_config", reg_config, ref_cfg);
        read_check(REG_ADDR_STATUS);
        write_reg(REG_ADDR_STATUS, 8'h40);
        wait_intb(ref_intb());

        rnd      = next_rand();
        idx      = int'(rnd % 6);
        flt_bits = 6'b1 << idx;
        hv_fault = hv_fault_t'(flt_bits);  // short glitch
        repeat (3) @(negedge clk);
        hv_fault = '0;
        repeat (2 * DEGLITCH) @(negedge clk);
        check_intb("o_intb_n", intb_n, ref_intb());
        read_check(REG_ADDR_STATUS);

        hv_fault       = hv_fault_t'(flt_bits);
        ref_status.flt = ref_status.flt | hv_fault_t'(flt_bits);
        wait_intb(ref_intb());
        read_check(REG_ADDR_STATUS);

        write_reg(REG_ADDR_INT_MASK, {2'b00, flt_bits});
        wait_intb(ref_intb());
        read_check(REG_ADDR_INT_MASK);
        read_check(REG_ADDR_STATUS);
        write_reg(REG_ADDR_INT_MASK, 8'h00);
        wait_intb(ref_intb());

        hv_fault = '0;
        repeat (4) @(negedge clk);
        write_reg(REG_ADDR_STATUS, {2'b00, flt_bits});
        wait_intb(ref_intb());
        read_check(REG_ADDR_STATUS);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/hv_core.sv */
//====================
// hv side digital core
// owt rx/tx, register slave, fault processing
//====================
`default_nettype none

module hv_core import owt_pkg::*; import hv_reg_pkg::*; #(
    parameter int OWT_BIT_CYCLES      = OWT_BIT_CYCLES_DEF,
    parameter int FLT_DEGLITCH_CYCLES = FLT_DEGLITCH_DEF
) (
    input  wire logic      i_clk,
    input  wire logic      i_arst_n,
    input  wire logic      i_lv_hv_owt_rx,
    output      logic      o_hv_lv_owt_tx,
    input  wire hv_fault_t i_hv_fault,
    output      drv_cfg_t  o_reg_config,
    output      logic      o_intb_n
);

    logic          frm_vld;
    owt_frame_t    frm;
    logic          com_err;
    logic          rsp_vld;
    owt_frame_t    rsp;
    logic          flt_clr_vld;
    fault_status_t flt_clr;
    fault_status_t int_mask;
    fault_status_t fault_status;

    hv_owt_rx #(
        .OWT_BIT_CYCLES (OWT_BIT_CYCLES)
    ) u_owt_rx (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_owt_rx  (i_lv_hv_owt_rx),
        .o_frm_vld (frm_vld),
        .o_frm     (frm),
        .o_com_err (com_err)
    );

    hv_owt_tx #(
        .OWT_BIT_CYCLES (OWT_BIT_CYCLES)
    ) u_owt_tx (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rsp_vld (rsp_vld),
        .i_rsp     (rsp),
        .o_owt_tx  (o_hv_lv_owt_tx)
    );

    hv_reg_slv u_reg_slv (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_frm_vld      (frm_vld),
        .i_frm          (frm),
        .i_fault_status (fault_status),
        .o_rsp_vld      (rsp_vld),
        .o_rsp          (rsp),
        .o_flt_clr_vld  (flt_clr_vld),
        .o_flt_clr      (flt_clr),
        .o_int_mask     (int_mask),
        .o_reg_config   (o_reg_config)
    );

    hv_fault_proc #(
        .FLT_DEGLITCH_CYCLES (FLT_DEGLITCH_CYCLES)
    ) u_fault_proc (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_hv_fault     (i_hv_fault),
        .i_com_err      (com_err),
        .i_flt_clr_vld  (flt_clr_vld),
        .i_flt_clr      (flt_clr),
        .i_int_mask     (int_mask),
        .o_fault_status (fault_status),
        .o_intb_n       (o_intb_n)
    );

endmodule

`default_nettype wire

/* hw/hv_fault_proc.sv */
//====================
// fault processing
// input sync, per-bit deglitch, sticky status, interrupt
//====================
`default_nettype none

module hv_fault_proc import hv_reg_pkg::*; #(
    parameter int FLT_DEGLITCH_CYCLES = FLT_DEGLITCH_DEF
) (
    input  wire logic          i_clk,
    input  wire logic          i_arst_n,
    input  wire hv_fault_t     i_hv_fault,
    input  wire logic          i_com_err,
    input  wire logic          i_flt_clr_vld,
    input  wire fault_status_t i_flt_clr,
    input  wire fault_status_t i_int_mask,
    output      fault_status_t o_fault_status,
    output      logic          o_intb_n
);

    localparam int FLT_N = $bits(hv_fault_t);
    localparam int CNT_W = (FLT_DEGLITCH_CYCLES > 1) ? $clog2(FLT_DEGLITCH_CYCLES) : 1;

    hv_fault_t        flt_meta;
    hv_fault_t        flt_sync;
    logic [CNT_W-1:0] flt_cnt [FLT_N];
    hv_fault_t        flt_det;
    fault_status_t    clr;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            flt_meta <= '0;
            flt_sync <= '0;
        end else begin
            flt_meta <= i_hv_fault;
            flt_sync <= flt_meta;
        end
    end

    //====================
    // deglitch, counter saturates at length-1
    //====================
    always_comb begin
        for (int i = 0; i < FLT_N; i++) begin
            flt_det[i] = flt_sync[i] && (flt_cnt[i] == CNT_W'(FLT_DEGLITCH_CYCLES - 1));
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < FLT_N; i++) flt_cnt[i] <= '0;
        end else begin
            for (int i = 0; i < FLT_N; i++) begin
                if (!flt_sync[i]) begin
                    flt_cnt[i] <= '0;
                end else if (!flt_det[i]) begin
                    flt_cnt[i] <= flt_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign clr = i_flt_clr_vld ? i_flt_clr : '0;

    // set wins over clear, so a held fault survives w1c
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_fault_status <= '0;
            o_intb_n       <= 1'b1;
        end else begin
            o_fault_status.flt     <= (o_fault_status.flt & ~clr.flt) | flt_det;
            o_fault_status.com_err <= (o_fault_status.com_err & ~clr.com_err) | i_com_err;
            o_intb_n               <= ~|(o_fault_status & ~i_int_mask);
        end
    end

endmodule

`default_nettype wire

/* hw/hv_reg_slv.sv */
//====================
// register slave
// command decode, config and mask registers
// status clear strobe, read responses
//====================
`default_nettype none

module hv_reg_slv import owt_pkg::*; import hv_reg_pkg::*; (
    input  wire logic          i_clk,
    input  wire logic          i_arst_n,
    input  wire logic          i_frm_vld,
    input  wire owt_frame_t    i_frm,
    input  wire fault_status_t i_fault_status,
    output      logic          o_rsp_vld,
    output      owt_frame_t    o_rsp,
    output      logic          o_flt_clr_vld,
    output      fault_status_t o_flt_clr,
    output      fault_status_t o_int_mask,
    output      drv_cfg_t      o_reg_config
);

    reg_addr_t     addr;
    logic          wr_en;
    logic          rd_en;
    owt_data_t     rd_data;
    drv_cfg_t      cfg_q;
    fault_status_t mask_q;

    // cmd[7] selects write, cmd[3:0] the address
    assign addr  = reg_addr_t'(i_frm.cmd[3:0]);
    assign wr_en = i_frm_vld & i_frm.cmd[7];
    assign rd_en = i_frm_vld & ~i_frm.cmd[7];

    //====================
    // writable registers
    //====================
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cfg_q  <= DRV_CFG_RST;
            mask_q <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_ADDR_CONFIG:   cfg_q  <= drv_cfg_t'(i_frm.data);
                REG_ADDR_INT_MASK: mask_q <= fault_status_t'(i_frm.data[6:0]);
                default: ;  // id, status and unmapped hold
            endcase
        end
    end

    // w1c on status, applied by fault processing at the next edge
    assign o_flt_clr_vld = wr_en && (addr == REG_ADDR_STATUS);
    assign o_flt_clr     = fault_status_t'(i_frm.data[6:0]);

    assign o_int_mask   = mask_q;
    assign o_reg_config = cfg_q;

    //====================
    // read path
    //====================
    always_comb begin
        case (addr)
            REG_ADDR_CONFIG:   rd_data = cfg_q;
            REG_ADDR_INT_MASK: rd_data = {1'b0, mask_q};
            REG_ADDR_STATUS:   rd_data = {1'b0, i_fault_status};
            REG_ADDR_ID:       rd_data = HV_CORE_ID;
            default:           rd_data = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rsp_vld <= 1'b0;
        end else begin
            o_rsp_vld <= rd_en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_en) begin
            o_rsp.cmd  <= i_frm.cmd;  // echo request
            o_rsp.data <= rd_data;
            o_rsp.crc  <= '0;         // filled in by tx
        end
    end

endmodule

`default_nettype wire

/* hw/hv_owt_tx.sv */
//====================
// one-wire transmitter
// inserts crc, sends start, frame and stop bits
//====================
`default_nettype none

module hv_owt_tx import owt_pkg::*; #(
    parameter int OWT_BIT_CYCLES = OWT_BIT_CYCLES_DEF
) (
    input  wire logic       i_clk,
    input  wire logic       i_arst_n,
    input  wire logic       i_rsp_vld,
    input  wire owt_frame_t i_rsp,
    output      logic       o_owt_tx
);

    localparam int TX_BITS = OWT_FRAME_W + 2;  // start + frame + stop
    localparam int CYC_W   = (OWT_BIT_CYCLES > 1) ? $clog2(OWT_BIT_CYCLES) : 1;
    localparam int BIT_W   = $clog2(TX_BITS);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t          state;
    owt_frame_t         rsp_crc;
    logic [TX_BITS-1:0] tx_sr;
    logic [CYC_W-1:0]   cyc_cnt;
    logic [BIT_W-1:0]   bit_cnt;

    always_comb begin
        rsp_crc     = i_rsp;
        rsp_crc.crc = owt_crc4(i_rsp.cmd, i_rsp.data);
    end

    assign o_owt_tx = tx_sr[TX_BITS-1];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= TX_IDLE;
            tx_sr   <= '1;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: if (i_rsp_vld) begin
                    tx_sr   <= {1'b0, rsp_crc, 1'b1};
                    cyc_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= TX_SEND;
                end
                TX_SEND: begin
                    // strobes while sending are dropped
                    if (cyc_cnt == CYC_W'(OWT_BIT_CYCLES - 1)) begin
                        cyc_cnt <= '0;
                        tx_sr   <= {tx_sr[TX_BITS-2:0], 1'b1};
                        if (bit_cnt == BIT_W'(TX_BITS - 1)) begin
                            state <= TX_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/hv_owt_rx.sv */
//====================
// one-wire receiver
// line sync, mid-bit sampling, stop bit and crc check
//====================
`default_nettype none

module hv_owt_rx import owt_pkg::*; #(
    parameter int OWT_BIT_CYCLES = OWT_BIT_CYCLES_DEF
) (
    input  wire logic       i_clk,
    input  wire logic       i_arst_n,
    input  wire logic       i_owt_rx,
    output      logic       o_frm_vld,
    output      owt_frame_t o_frm,
    output      logic       o_com_err
);

    localparam int CYC_W = (OWT_BIT_CYCLES > 1) ? $clog2(OWT_BIT_CYCLES) : 1;
    localparam int BIT_W = $clog2(OWT_FRAME_W);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t              state;
    logic [1:0]             rx_sync;
    logic                   rx_s;
    logic [CYC_W-1:0]       cyc_cnt;
    logic [BIT_W-1:0]       bit_cnt;
    logic [OWT_FRAME_W-1:0] frm_sr;
    logic                   half_tick;
    logic                   bit_tick;
    logic                   crc_ok;

    assign rx_s      = rx_sync[1];
    assign half_tick = (cyc_cnt == CYC_W'(OWT_BIT_CYCLES / 2 - 1));
    assign bit_tick  = (cyc_cnt == CYC_W'(OWT_BIT_CYCLES - 1));
    assign o_frm     = frm_sr;
    assign crc_ok    = (owt_crc4(o_frm.cmd, o_frm.data) == o_frm.crc);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_sync <= 2'b11;  // idle high
        end else begin
            rx_sync <= {rx_sync[0], i_owt_rx};
        end
    end

    //====================
    // frame fsm
    //====================
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= RX_IDLE;
            cyc_cnt   <= '0;
            bit_cnt   <= '0;
            o_frm_vld <= 1'b0;
            o_com_err <= 1'b0;
        end else begin
            o_frm_vld <= 1'b0;
            o_com_err <= 1'b0;
            cyc_cnt   <= cyc_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cyc_cnt <= '0;
                    bit_cnt <= '0;
                    if (!rx_s) state <= RX_START;
                end
                RX_START: if (half_tick) begin
                    cyc_cnt <= '0;
                    state   <= rx_s ? RX_IDLE : RX_DATA;  // glitch back to idle
                end
                RX_DATA: if (bit_tick) begin
                    cyc_cnt <= '0;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_W'(OWT_FRAME_W - 1)) state <= RX_STOP;
                end
                RX_STOP: if (bit_tick) begin
                    state     <= RX_IDLE;
                    o_frm_vld <= rx_s & crc_ok;
                    o_com_err <= ~(rx_s & crc_ok);
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_tick) begin
            frm_sr <= {frm_sr[OWT_FRAME_W-2:0], rx_s};  // msb first
        end
    end

endmodule

`default_nettype wire

/* hw/hv_reg_pkg.sv */
//====================
// hv register map
// addresses, drive config and fault structs, chip id, deglitch default
//====================
`default_nettype none

package hv_reg_pkg;

    typedef logic [3:0] reg_addr_t;

    localparam reg_addr_t REG_ADDR_CONFIG   = 4'd0;
    localparam reg_addr_t REG_ADDR_INT_MASK = 4'd1;
    localparam reg_addr_t REG_ADDR_STATUS   = 4'd2;
    localparam reg_addr_t REG_ADDR_ID       = 4'd3;

    // drive strength and desat threshold selects
    typedef struct packed {
        logic [2:0] src_sel;
        logic [2:0] snk_sel;
        logic [1:0] desat_sel;
    } drv_cfg_t;

    localparam drv_cfg_t DRV_CFG_RST = '0;

    typedef struct packed {
        logic vcc_uv;
        logic vcc_ov;
        logic ot;
        logic oc;
        logic desat;
        logic scp;
    } hv_fault_t;

    // low 7 bits of the status register
    typedef struct packed {
        logic      com_err;
        hv_fault_t flt;
    } fault_status_t;

    localparam logic [7:0] HV_CORE_ID       = 8'hA5;
    localparam int         FLT_DEGLITCH_DEF = 8;

endpackage

`default_nettype wire

/* hw/owt_pkg.sv */
//====================
// one-wire link definitions
// frame fields, frame struct, bit timing default, crc-4 function
//====================
`default_nettype none

package owt_pkg;

    typedef logic [7:0] owt_cmd_t;   // [7] write, [3:0] register address
    typedef logic [7:0] owt_data_t;
    typedef logic [3:0] owt_crc_t;

    typedef struct packed {
        owt_cmd_t  cmd;
        owt_data_t data;
        owt_crc_t  crc;
    } owt_frame_t;

    localparam int       OWT_FRAME_W        = $bits(owt_frame_t);
    localparam owt_crc_t OWT_CRC_POLY       = 4'h3;  // x^4 + x + 1
    localparam int       OWT_BIT_CYCLES_DEF = 16;

    // crc over cmd then data, msb first, zero seed
    function automatic owt_crc_t owt_crc4(input owt_cmd_t cmd, input owt_data_t data);
        logic [15:0] msg;
        owt_crc_t    crc;
        msg = {cmd, data};
        crc = '0;
        for (int i = 15; i >= 0; i--) begin
            if (crc[3] ^ msg[i]) begin
                crc = {crc[2:0], 1'b0} ^ OWT_CRC_POLY;
            end else begin
                crc = {crc[2:0], 1'b0};
            end
        end
        return crc;
    endfunction

endpackage

`default_nettype wire
